//--- source/pinmux_pkg.sv
// Fixed pin map for the 23 Arduino pads of ports B, C and D
// PC7 has no pad, so its GPIO bit (15) is never stored and always reads 0
package pinmux_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int PAD_W   = 23;
  localparam int GPIO_W  = 24;
  localparam int STRAP_W = 6;
  localparam int PWM_N   = 6;
  localparam int WS_N    = 4;
  localparam int CS_N    = 4;
  localparam int REG_DW  = 32;
  localparam int REG_AW  = 2;

  typedef logic [PAD_W-1:0]   pad_vec_t;
  // Port B in 7:0, port C in 15:8, port D in 23:16
  typedef logic [GPIO_W-1:0]  gpio_vec_t;
  typedef logic [STRAP_W-1:0] strap_t;
  typedef logic [REG_DW-1:0]  reg_data_t;
  typedef logic [REG_AW-1:0]  reg_addr_t;

  // --------------------
  // Function word layout
  // --------------------
  localparam int FS_PWM_LSB  = 0;   // 6 bits
  localparam int FS_INT_LSB  = 6;   // 2 bits
  localparam int FS_UART_LSB = 8;   // 2 bits
  localparam int FS_SPIM     = 10;
  localparam int FS_CS_LSB   = 11;  // 4 bits
  localparam int FS_I2C      = 15;

  // Register map
  localparam reg_addr_t ADDR_DIR  = 2'd0;  // 1 = output
  localparam reg_addr_t ADDR_TYPE = 2'd1;  // 1 = WS281x
  localparam reg_addr_t ADDR_FUNC = 2'd2;
  localparam reg_addr_t ADDR_CTRL = 2'd3;  // bit 0 strap pad control

  // Storable GPIO bits, PC7 excluded
  localparam gpio_vec_t GPIO_MASK = 24'hFF_7FFF;

  // GPIO bit owned by each pad, p0 first
  localparam int PAD_GPIO_IDX [PAD_W] = '{
    14, 16, 17, 18, 19, 20,  6,  7, 21, 22, 23,  0,
     1,  2,  3,  4,  5,  8,  9, 10, 11, 12, 13
  };

  // Strap pads
  localparam int STRAP_PAD0 = 2;
  localparam int STRAP_PAD1 = 5;
  localparam int STRAP_PAD2 = 8;
  localparam int STRAP_PAD3 = 12;
  localparam int STRAP_PAD4 = 13;
  localparam int STRAP_PAD5 = 16;

  localparam pad_vec_t STRAP_MASK =
    (pad_vec_t'(1) << STRAP_PAD0) | (pad_vec_t'(1) << STRAP_PAD1) |
    (pad_vec_t'(1) << STRAP_PAD2) | (pad_vec_t'(1) << STRAP_PAD3) |
    (pad_vec_t'(1) << STRAP_PAD4) | (pad_vec_t'(1) << STRAP_PAD5);

endpackage

//--- source/pinmux_cfg_regs.sv
// Plain write strobe, no handshake; new values take effect from the next cycle
// Read-back is combinational on reg_addr_i
`timescale 1ns/1ps

module pinmux_cfg_regs
  import pinmux_pkg::*;
(
  input  logic      mclk,
  input  logic      rst_i,
  input  logic      reg_wr_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output gpio_vec_t cfg_dir_o,
  output gpio_vec_t cfg_type_o,
  output reg_data_t cfg_func_o,
  output logic      cfg_strap_ctrl_o
);

  gpio_vec_t dir_q;
  gpio_vec_t type_q;
  reg_data_t func_q;
  logic      strap_ctrl_q;

  // --------------------
  // Register write
  // --------------------
  always_ff @(posedge mclk) begin
    if (rst_i) begin
      dir_q        <= '0;
      type_q       <= '0;
      func_q       <= '0;
      // Strap pads held as inputs out of reset
      strap_ctrl_q <= 1'b1;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        ADDR_DIR:  dir_q        <= reg_wdata_i[GPIO_W-1:0] & GPIO_MASK;
        ADDR_TYPE: type_q       <= reg_wdata_i[GPIO_W-1:0] & GPIO_MASK;
        ADDR_FUNC: func_q       <= reg_wdata_i;
        ADDR_CTRL: strap_ctrl_q <= reg_wdata_i[0];
        default: ;
      endcase
    end
  end

  // --------------------
  // Read-back mux
  // --------------------
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      ADDR_DIR:  reg_rdata_o = {{(REG_DW-GPIO_W){1'b0}}, dir_q};
      ADDR_TYPE: reg_rdata_o = {{(REG_DW-GPIO_W){1'b0}}, type_q};
      ADDR_FUNC: reg_rdata_o = func_q;
      ADDR_CTRL: reg_rdata_o = {{(REG_DW-1){1'b0}}, strap_ctrl_q};
      default:   reg_rdata_o = '0;
    endcase
  end

  // To both routers
  assign cfg_dir_o        = dir_q;
  assign cfg_type_o       = type_q;
  assign cfg_func_o       = func_q;
  assign cfg_strap_ctrl_o = strap_ctrl_q;

endmodule

//--- source/pinmux_in_route.sv
// Purely combinational; disabled peripheral inputs sit at their idle level
// UART RXD idles high, all other inputs idle low
`timescale 1ns/1ps

module pinmux_in_route
  import pinmux_pkg::*;
(
  input  pad_vec_t   pad_in_i,
  input  reg_data_t  cfg_func_i,
  output gpio_vec_t  gpio_in_o,
  output strap_t     strap_o,
  output logic [1:0] uart_rxd_o,
  output logic [1:0] ext_intr_o,
  output logic       spim_mosi_o,
  output logic       i2cm_data_o_in,
  output logic       i2cm_clk_o_in
);

  logic [1:0] int_enb;
  logic [1:0] uart_enb;
  logic       spim_enb;
  logic       i2cm_enb;

  // Only the enables with an input path
  assign int_enb  = cfg_func_i[FS_INT_LSB +: 2];
  assign uart_enb = cfg_func_i[FS_UART_LSB +: 2];
  assign spim_enb = cfg_func_i[FS_SPIM];
  assign i2cm_enb = cfg_func_i[FS_I2C];

  // --------------------
  // GPIO and straps
  // --------------------
  // Pads scattered back into port order, PC7 left at 0
  always_comb begin
    gpio_in_o = '0;
    for (int p = 0; p < PAD_W; p++) begin
      gpio_in_o[PAD_GPIO_IDX[p]] = pad_in_i[p];
    end
  end

  // Sampled regardless of strap control
  assign strap_o = {pad_in_i[STRAP_PAD5], pad_in_i[STRAP_PAD4],
                    pad_in_i[STRAP_PAD3], pad_in_i[STRAP_PAD2],
                    pad_in_i[STRAP_PAD1], pad_in_i[STRAP_PAD0]};

  // --------------------
  // Peripheral inputs
  // --------------------
  always_comb begin
    uart_rxd_o     = 2'b11;
    ext_intr_o     = 2'b00;
    spim_mosi_o    = 1'b0;
    i2cm_data_o_in = 1'b0;
    i2cm_clk_o_in  = 1'b0;

    // PD0 RXD0
    if (uart_enb[0]) begin
      uart_rxd_o[0] = pad_in_i[1];
    end

    // PD2 shared by RXD1 and INT0, UART has priority
    if (uart_enb[1]) begin
      uart_rxd_o[1] = pad_in_i[3];
    end else if (int_enb[0]) begin
      ext_intr_o[0] = pad_in_i[3];
    end

    // PD3 INT1
    if (int_enb[1]) begin
      ext_intr_o[1] = pad_in_i[4];
    end

    // PB3 MOSI
    if (spim_enb) begin
      spim_mosi_o = pad_in_i[14];
    end

    // PC4 SDA, PC5 SCL
    if (i2cm_enb) begin
      i2cm_data_o_in = pad_in_i[21];
      i2cm_clk_o_in  = pad_in_i[22];
    end
  end

endmodule

//--- source/pinmux_out_route.sv
// Purely combinational; oen is active low, idle pads are inputs driving 0
// Strap control forces oen high on strap pads, out still follows the chain
`timescale 1ns/1ps

module pinmux_out_route
  import pinmux_pkg::*;
(
  input  gpio_vec_t        cfg_dir_i,
  input  gpio_vec_t        cfg_type_i,
  input  reg_data_t        cfg_func_i,
  input  logic             cfg_strap_ctrl_i,
  input  gpio_vec_t        gpio_out_i,
  input  logic [PWM_N-1:0] pwm_wfm_i,
  input  logic [WS_N-1:0]  ws_txd_i,
  input  logic [1:0]       uart_txd_i,
  input  logic             spim_sck_i,
  input  logic             spim_miso_i,
  input  logic [CS_N-1:0]  spim_ssn_i,
  input  logic             i2cm_data_i,
  input  logic             i2cm_data_oen_i,
  input  logic             i2cm_clk_i,
  input  logic             i2cm_clk_oen_i,
  output pad_vec_t         pad_out_o,
  output pad_vec_t         pad_oen_o
);

  logic [PWM_N-1:0] pwm_enb;
  logic [1:0]       int_enb;
  logic [1:0]       uart_enb;
  logic             spim_enb;
  logic [CS_N-1:0]  cs_enb;
  logic             i2cm_enb;
  pad_vec_t         pad_dir;   // Per pad, in pad order
  pad_vec_t         pad_ws;
  pad_vec_t         pad_gpio;
  pad_vec_t         out_c;
  pad_vec_t         oen_c;

  assign pwm_enb  = cfg_func_i[FS_PWM_LSB +: PWM_N];
  assign int_enb  = cfg_func_i[FS_INT_LSB +: 2];
  assign uart_enb = cfg_func_i[FS_UART_LSB +: 2];
  assign spim_enb = cfg_func_i[FS_SPIM];
  assign cs_enb   = cfg_func_i[FS_CS_LSB +: CS_N];
  assign i2cm_enb = cfg_func_i[FS_I2C];

  // Gather port-ordered GPIO config into pad order
  always_comb begin
    for (int p = 0; p < PAD_W; p++) begin
      pad_dir[p]  = cfg_dir_i[PAD_GPIO_IDX[p]];
      pad_ws[p]   = cfg_type_i[PAD_GPIO_IDX[p]];
      pad_gpio[p] = gpio_out_i[PAD_GPIO_IDX[p]];
    end
  end

  // Tail of every chain, {out, oen}
  function automatic logic [1:0] ws_gpio(input logic ws_en, input logic ws_bit,
                                         input logic dir_en, input logic gpio_bit);
    logic [1:0] r;
    r = 2'b01;
    if (ws_en) begin
      r = {ws_bit, 1'b0};
    end else if (dir_en) begin
      r = {gpio_bit, 1'b0};
    end
    return r;
  endfunction

  always_comb begin
    out_c = '0;
    oen_c = '1;

    // --------------------
    // Port D
    // --------------------
    // PD0, RXD0 keeps it an input
    if (!uart_enb[0]) begin
      {out_c[1], oen_c[1]} = ws_gpio(pad_ws[1], ws_txd_i[0], pad_dir[1], pad_gpio[1]);
    end
    // PD1 TXD0
    if (uart_enb[0]) begin
      {out_c[2], oen_c[2]} = {uart_txd_i[0], 1'b0};
    end else begin
      {out_c[2], oen_c[2]} = ws_gpio(pad_ws[2], ws_txd_i[0], pad_dir[2], pad_gpio[2]);
    end
    // PD2, INT0 keeps it an input
    if (!int_enb[0]) begin
      {out_c[3], oen_c[3]} = ws_gpio(pad_ws[3], ws_txd_i[0], pad_dir[3], pad_gpio[3]);
    end
    // PD3, PWM0 over INT1
    if (pwm_enb[0]) begin
      {out_c[4], oen_c[4]} = {pwm_wfm_i[0], 1'b0};
    end else if (!int_enb[1]) begin
      {out_c[4], oen_c[4]} = ws_gpio(pad_ws[4], ws_txd_i[1], pad_dir[4], pad_gpio[4]);
    end
    // PD4 TXD1
    if (uart_enb[1]) begin
      {out_c[5], oen_c[5]} = {uart_txd_i[1], 1'b0};
    end else begin
      {out_c[5], oen_c[5]} = ws_gpio(pad_ws[5], ws_txd_i[1], pad_dir[5], pad_gpio[5]);
    end
    // PD5 and PD6, PWM over chip select
    if (pwm_enb[1]) begin
      {out_c[8], oen_c[8]} = {pwm_wfm_i[1], 1'b0};
    end else if (cs_enb[3]) begin
      {out_c[8], oen_c[8]} = {spim_ssn_i[3], 1'b0};
    end else begin
      {out_c[8], oen_c[8]} = ws_gpio(pad_ws[8], ws_txd_i[2], pad_dir[8], pad_gpio[8]);
    end
    if (pwm_enb[2]) begin
      {out_c[9], oen_c[9]} = {pwm_wfm_i[2], 1'b0};
    end else if (cs_enb[2]) begin
      {out_c[9], oen_c[9]} = {spim_ssn_i[2], 1'b0};
    end else begin
      {out_c[9], oen_c[9]} = ws_gpio(pad_ws[9], ws_txd_i[2], pad_dir[9], pad_gpio[9]);
    end
    // PD7
    {out_c[10], oen_c[10]} = ws_gpio(pad_ws[10], ws_txd_i[2], pad_dir[10], pad_gpio[10]);

    // --------------------
    // Port B
    // --------------------
    // PB6, PB7, PB0 plain
    {out_c[6], oen_c[6]} = ws_gpio(pad_ws[6], ws_txd_i[1], pad_dir[6], pad_gpio[6]);
    {out_c[7], oen_c[7]} = ws_gpio(pad_ws[7], ws_txd_i[1], pad_dir[7], pad_gpio[7]);
    {out_c[11], oen_c[11]} = ws_gpio(pad_ws[11], ws_txd_i[2], pad_dir[11], pad_gpio[11]);
    // PB1 and PB2, PWM over chip select
    if (pwm_enb[3]) begin
      {out_c[12], oen_c[12]} = {pwm_wfm_i[3], 1'b0};
    end else if (cs_enb[1]) begin
      {out_c[12], oen_c[12]} = {spim_ssn_i[1], 1'b0};
    end else begin
      {out_c[12], oen_c[12]} = ws_gpio(pad_ws[12], ws_txd_i[3], pad_dir[12], pad_gpio[12]);
    end
    if (pwm_enb[4]) begin
      {out_c[13], oen_c[13]} = {pwm_wfm_i[4], 1'b0};
    end else if (cs_enb[0]) begin
      {out_c[13], oen_c[13]} = {spim_ssn_i[0], 1'b0};
    end else begin
      {out_c[13], oen_c[13]} = ws_gpio(pad_ws[13], ws_txd_i[3], pad_dir[13], pad_gpio[13]);
    end
    // PB3, MOSI input wins over PWM5
    if (!spim_enb) begin
      if (pwm_enb[5]) begin
        {out_c[14], oen_c[14]} = {pwm_wfm_i[5], 1'b0};
      end else begin
        {out_c[14], oen_c[14]} = ws_gpio(pad_ws[14], ws_txd_i[3], pad_dir[14], pad_gpio[14]);
      end
    end
    // PB4 MISO, PB5 SCK without WS281x
    if (spim_enb) begin
      {out_c[15], oen_c[15]} = {spim_miso_i, 1'b0};
      {out_c[16], oen_c[16]} = {spim_sck_i, 1'b0};
    end else begin
      {out_c[15], oen_c[15]} = ws_gpio(pad_ws[15], ws_txd_i[3], pad_dir[15], pad_gpio[15]);
      {out_c[16], oen_c[16]} = ws_gpio(1'b0, 1'b0, pad_dir[16], pad_gpio[16]);
    end

    // --------------------
    // Port C
    // --------------------
    {out_c[0], oen_c[0]} = ws_gpio(pad_ws[0], ws_txd_i[0], pad_dir[0], pad_gpio[0]);
    // PC0..PC3 plain GPIO
    for (int p = 17; p <= 20; p++) begin
      {out_c[p], oen_c[p]} = ws_gpio(1'b0, 1'b0, pad_dir[p], pad_gpio[p]);
    end
    // PC4 SDA, PC5 SCL, open drain handled by the I2C master oen
    if (i2cm_enb) begin
      {out_c[21], oen_c[21]} = {i2cm_data_i, i2cm_data_oen_i};
      {out_c[22], oen_c[22]} = {i2cm_clk_i, i2cm_clk_oen_i};
    end else begin
      {out_c[21], oen_c[21]} = ws_gpio(1'b0, 1'b0, pad_dir[21], pad_gpio[21]);
      {out_c[22], oen_c[22]} = ws_gpio(1'b0, 1'b0, pad_dir[22], pad_gpio[22]);
    end
  end

  assign pad_out_o = out_c;
  // Strap override on oen only
  assign pad_oen_o = cfg_strap_ctrl_i ? (oen_c | STRAP_MASK) : oen_c;

endmodule

//--- source/pinmux_top.sv
// Register block plus two combinational routers, no shared bus
// cfg_pwm_enb_o feeds the external PWM block
`timescale 1ns/1ps

module pinmux_top
  import pinmux_pkg::*;
(
  input  logic             mclk,
  input  logic             rst_i,
  // Register write and read-back
  input  logic             reg_wr_i,
  input  reg_addr_t        reg_addr_i,
  input  reg_data_t        reg_wdata_i,
  output reg_data_t        reg_rdata_o,
  // Pads
  input  pad_vec_t         pad_in_i,
  output pad_vec_t         pad_out_o,
  output pad_vec_t         pad_oen_o,
  output strap_t           strap_o,
  // GPIO
  output gpio_vec_t        gpio_in_o,
  input  gpio_vec_t        gpio_out_i,
  // PWM and WS281x
  output logic [PWM_N-1:0] cfg_pwm_enb_o,
  input  logic [PWM_N-1:0] pwm_wfm_i,
  input  logic [WS_N-1:0]  ws_txd_i,
  // UART and interrupts
  input  logic [1:0]       uart_txd_i,
  output logic [1:0]       uart_rxd_o,
  output logic [1:0]       ext_intr_o,
  // SPI master
  input  logic             spim_sck_i,
  input  logic             spim_miso_i,
  input  logic [CS_N-1:0]  spim_ssn_i,
  output logic             spim_mosi_o,
  // I2C master
  input  logic             i2cm_data_i,
  input  logic             i2cm_data_oen_i,
  input  logic             i2cm_clk_i,
  input  logic             i2cm_clk_oen_i,
  output logic             i2cm_data_in_o,
  output logic             i2cm_clk_in_o
);

  gpio_vec_t cfg_dir;
  gpio_vec_t cfg_type;
  reg_data_t cfg_func;
  logic      cfg_strap_ctrl;

  assign cfg_pwm_enb_o = cfg_func[FS_PWM_LSB +: PWM_N];

  pinmux_cfg_regs u_cfg_regs (
    .mclk             (mclk),
    .rst_i            (rst_i),
    .reg_wr_i         (reg_wr_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .reg_rdata_o      (reg_rdata_o),
    .cfg_dir_o        (cfg_dir),
    .cfg_type_o       (cfg_type),
    .cfg_func_o       (cfg_func),
    .cfg_strap_ctrl_o (cfg_strap_ctrl)
  );

  // Pad to peripheral
  pinmux_in_route u_in_route (
    .pad_in_i       (pad_in_i),
    .cfg_func_i     (cfg_func),
    .gpio_in_o      (gpio_in_o),
    .strap_o        (strap_o),
    .uart_rxd_o     (uart_rxd_o),
    .ext_intr_o     (ext_intr_o),
    .spim_mosi_o    (spim_mosi_o),
    .i2cm_data_o_in (i2cm_data_in_o),
    .i2cm_clk_o_in  (i2cm_clk_in_o)
  );

  // Peripheral to pad
  pinmux_out_route u_out_route (
    .cfg_dir_i        (cfg_dir),
    .cfg_type_i       (cfg_type),
    .cfg_func_i       (cfg_func),
    .cfg_strap_ctrl_i (cfg_strap_ctrl),
    .gpio_out_i       (gpio_out_i),
    .pwm_wfm_i        (pwm_wfm_i),
    .ws_txd_i         (ws_txd_i),
    .uart_txd_i       (uart_txd_i),
    .spim_sck_i       (spim_sck_i),
    .spim_miso_i      (spim_miso_i),
    .spim_ssn_i       (spim_ssn_i),
    .i2cm_data_i      (i2cm_data_i),
    .i2cm_data_oen_i  (i2cm_data_oen_i),
    .i2cm_clk_i       (i2cm_clk_i),
    .i2cm_clk_oen_i   (i2cm_clk_oen_i),
    .pad_out_o        (pad_out_o),
    .pad_oen_o        (pad_oen_o)
  );

endmodule

//--- sim/pinmux_top_chk.sv
// Bound into pinmux_top, sees the internal strap control and function word
// Sampled on mclk, the routed pads being combinational
`timescale 1ns/1ps

module pinmux_top_chk
  import pinmux_pkg::*;
(
  input logic       mclk,
  input logic       rst_i,
  input logic       strap_ctrl_i,
  input reg_data_t  func_i,
  input pad_vec_t   pad_oen_i,
  input logic [1:0] uart_rxd_i
);

  // Strap pads p2, p5, p8, p12, p13, p16 held as inputs
  strap_pads_in: assert property (@(posedge mclk) disable iff (rst_i)
    strap_ctrl_i |-> (pad_oen_i[2] && pad_oen_i[5] && pad_oen_i[8] &&
                      pad_oen_i[12] && pad_oen_i[13] && pad_oen_i[16]))
    else $error("Strap pad driven while strap control is set");

  // Cleared config leaves every pad an input
  reset_pads_in: assert property (@(posedge mclk) rst_i |=> (&pad_oen_i))
    else $error("Pad output enabled in the cycle after reset");

  // Disabled UARTs see an idle line
  uart_idle: assert property (@(posedge mclk) disable iff (rst_i)
    (func_i[FS_UART_LSB +: 2] == 2'b00) |-> (uart_rxd_i == 2'b11))
    else $error("UART RXD not idle with both UARTs disabled");

endmodule

bind pinmux_top pinmux_top_chk u_chk (
  .mclk         (mclk),
  .rst_i        (rst_i),
  .strap_ctrl_i (cfg_strap_ctrl),
  .func_i       (cfg_func),
  .pad_oen_i    (pad_oen_o),
  .uart_rxd_i   (uart_rxd_o)
);

//--- sim/pinmux_top_tb.sv
// Table-driven testbench that stops at the first mismatch
// GPIO rows use seeded $urandom and get their expected values from a pad model
`timescale 1ns/1ps

module pinmux_top_tb
  import pinmux_pkg::*;
();

  localparam int          N_RANDOM    = 4;
  localparam int          N_ROWS      = 6 + N_RANDOM;
  localparam int          TIMEOUT_CYC = 20 * N_ROWS + 50;
  localparam logic [31:0] SEED        = 32'hc753_9931;

  // GPIO bit behind each pad in the order PC6, PD0..PD4, PB6, PB7, PD5..PD7, PB0..PB5, PC0..PC5
  localparam int GPIO_OF_PAD [PAD_W] = '{
    14, 16, 17, 18, 19, 20,  6,  7, 21, 22, 23,  0,
     1,  2,  3,  4,  5,  8,  9, 10, 11, 12, 13
  };
  // WS281x channel per pad with -1 where the pad has none
  localparam int WS_OF_PAD [PAD_W] = '{
     0,  0,  0,  0,  1,  1,  1,  1,  2,  2,  2,  2,
     3,  3,  3,  3, -1, -1, -1, -1, -1, -1, -1
  };

  typedef struct packed {
    gpio_vec_t        dir;
    gpio_vec_t        typ;
    reg_data_t        func;
    logic             ctrl;
    pad_vec_t         pad_in;
    gpio_vec_t        gpio_out;
    logic [PWM_N-1:0] pwm;
    logic [WS_N-1:0]  ws;
    logic [1:0]       txd;
    logic [CS_N-1:0]  ssn;
    logic [1:0]       spi;       // {sck, miso}
    logic [3:0]       i2c;       // {data, data_oen, clk, clk_oen}
    pad_vec_t         exp_out;
    pad_vec_t         exp_oen;
    logic [1:0]       exp_rxd;
    logic [1:0]       exp_int;
    logic             exp_mosi;
    logic [1:0]       exp_i2c;   // {data_in, clk_in}
  } row_t;

  logic mclk, rst_i, reg_wr_i;
  reg_addr_t reg_addr_i;
  reg_data_t reg_wdata_i, reg_rdata_o;
  pad_vec_t pad_in_i, pad_out_o, pad_oen_o;
  strap_t strap_o;
  gpio_vec_t gpio_in_o, gpio_out_i;
  logic [PWM_N-1:0] cfg_pwm_enb_o, pwm_wfm_i;
  logic [WS_N-1:0] ws_txd_i;
  logic [1:0] uart_txd_i, uart_rxd_o, ext_intr_o;
  logic spim_sck_i, spim_miso_i, spim_mosi_o;
  logic [CS_N-1:0] spim_ssn_i;
  logic i2cm_data_i, i2cm_data_oen_i, i2cm_clk_i, i2cm_clk_oen_i;
  logic i2cm_data_in_o, i2cm_clk_in_o;

  row_t rows[$];
  int   cycle_cnt = 0;

  pinmux_top pinmux_top_i (.*);

  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  // Watchdog on the whole run
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      abort_run($sformatf("Timeout after %0d cycles, the sequence did not finish", cycle_cnt));
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("FAIL at time %0t: %s = %h, expected %h", $time, what, got, exp));
  endtask

  function automatic strap_t strap_of(input pad_vec_t pads);
    return {pads[16], pads[13], pads[12], pads[8], pads[5], pads[2]};
  endfunction

  function automatic gpio_vec_t gpio_in_of(input pad_vec_t pads);
    gpio_vec_t g;
    g = '0;
    for (int p = 0; p < PAD_W; p++) begin
      g[GPIO_OF_PAD[p]] = pads[p];
    end
    return g;
  endfunction

  task automatic add_row(input gpio_vec_t dir, input gpio_vec_t typ, input reg_data_t func,
                         input logic ctrl, input pad_vec_t pad_in, input gpio_vec_t gpio_out,
                         input logic [5:0] pwm, input logic [3:0] ws, input logic [1:0] txd,
                         input logic [3:0] ssn, input logic [1:0] spi, input logic [3:0] i2c,
                         input pad_vec_t exp_out, input pad_vec_t exp_oen,
                         input logic [1:0] exp_rxd, input logic [1:0] exp_int,
                         input logic exp_mosi, input logic [1:0] exp_i2c);
    rows.push_back({dir, typ, func, ctrl, pad_in, gpio_out, pwm, ws, txd, ssn, spi, i2c,
                    exp_out, exp_oen, exp_rxd, exp_int, exp_mosi, exp_i2c});
  endtask

  // Plain GPIO with no function and no strap control
  task automatic add_gpio_row();
    row_t        r;
    logic [31:0] rnd;
    int          g;
    int          w;
    r = '0;
    rnd = $urandom();
    r.dir = rnd[23:0];
    rnd = $urandom();
    r.typ = rnd[23:0];
    rnd = $urandom();
    r.gpio_out = rnd[23:0];
    rnd = $urandom();
    r.pad_in = rnd[22:0];
    // Peripheral noise that must not reach the pads
    rnd = $urandom();
    r.pwm = rnd[5:0];
    r.txd = rnd[7:6];
    r.ssn = rnd[11:8];
    r.spi = rnd[13:12];
    r.i2c = rnd[17:14];
    r.ws  = rnd[21:18];
    r.exp_rxd = 2'b11;
    for (int p = 0; p < PAD_W; p++) begin
      g = GPIO_OF_PAD[p];
      w = WS_OF_PAD[p];
      if (w >= 0 && r.typ[g]) begin
        r.exp_out[p] = r.ws[w];
        r.exp_oen[p] = 1'b0;
      end else if (r.dir[g]) begin
        r.exp_out[p] = r.gpio_out[g];
        r.exp_oen[p] = 1'b0;
      end else begin
        r.exp_out[p] = 1'b0;
        r.exp_oen[p] = 1'b1;
      end
    end
    rows.push_back(r);
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic load_table();
    // Strap control keeps p2 p5 p8 p12 p13 p16 as inputs
    add_row(24'hFF7FFF, 24'h0, 32'h0, 1'b1, 23'h5A5A5A, 24'hFFFFFF, 6'h0, 4'h0, 2'b00,
            4'h0, 2'b00, 4'h0, 23'h7FFFFF, 23'h013124, 2'b11, 2'b00, 1'b0, 2'b00);
    // Both UARTs and both INTs with INT0 masked by UART1
    add_row(24'h0, 24'h0, 32'h3C0, 1'b0, 23'h000018, 24'h0, 6'h0, 4'h0, 2'b11,
            4'h0, 2'b00, 4'h0, 23'h000024, 23'h7FFFDB, 2'b10, 2'b10, 1'b0, 2'b00);
    // UART0 and both INTs
    add_row(24'h0, 24'h0, 32'h1C0, 1'b0, 23'h000018, 24'h0, 6'h0, 4'h0, 2'b11,
            4'h0, 2'b00, 4'h0, 23'h000004, 23'h7FFFFB, 2'b10, 2'b11, 1'b0, 2'b00);
    // PWM1 and PWM4 over all chip selects with every pad WS281x
    add_row(24'h0, 24'hFF7FFF, 32'h7812, 1'b0, 23'h0, 24'h0, 6'h10, 4'h5, 2'b00,
            4'hA, 2'b00, 4'h0, 23'h003C0F, 23'h7F0000, 2'b11, 2'b00, 1'b0, 2'b00);
    // CS3 and CS0 over WS281x
    add_row(24'h0, 24'hFF7FFF, 32'h4800, 1'b0, 23'h0, 24'h0, 6'h00, 4'h5, 2'b00,
            4'h1, 2'b00, 4'h0, 23'h002E0F, 23'h7F0000, 2'b11, 2'b00, 1'b0, 2'b00);
    // SPI master with PWM5 and I2C on a board of output pads
    add_row(24'hFF7FFF, 24'h0, 32'h8420, 1'b0, 23'h204000, 24'h0, 6'h20, 4'h0, 2'b00,
            4'h0, 2'b11, 4'hE, 23'h618000, 23'h204000, 2'b11, 2'b00, 1'b1, 2'b10);
    for (int i = 0; i < N_RANDOM; i++) begin
      add_gpio_row();
    end
  endtask

  // --------------------
  // Sequencing
  // --------------------
  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge mclk);
    #2;
    reg_wr_i = 1'b0;
  endtask

  task automatic drive_inputs(input row_t r);
    pad_in_i   = r.pad_in;
    gpio_out_i = r.gpio_out;
    pwm_wfm_i  = r.pwm;
    ws_txd_i   = r.ws;
    uart_txd_i = r.txd;
    spim_ssn_i = r.ssn;
    {spim_sck_i, spim_miso_i} = r.spi;
    {i2cm_data_i, i2cm_data_oen_i, i2cm_clk_i, i2cm_clk_oen_i} = r.i2c;
  endtask

  task automatic check_reset();
    for (int a = 0; a < 4; a++) begin
      @(posedge mclk);
      #2;
      reg_addr_i = reg_addr_t'(a);
      @(negedge mclk);
      // Only CTRL comes up set
      check_val($sformatf("reset readback %0d", a), reg_rdata_o, (a == 3) ? 32'd1 : 32'd0);
    end
    check_val("reset pad_oen", 32'(pad_oen_o), 32'h007F_FFFF);
    check_val("reset pad_out", 32'(pad_out_o), 32'h0);
    check_val("reset uart_rxd", 32'(uart_rxd_o), 32'h3);
  endtask

  task automatic apply_row(input int idx, input row_t r);
    string     tag;
    reg_data_t exp_rd [4];
    tag = $sformatf("row %0d", idx);
    // PC7 (bit 15) is never stored
    exp_rd[0] = {8'h00, r.dir & 24'hFF7FFF};
    exp_rd[1] = {8'h00, r.typ & 24'hFF7FFF};
    exp_rd[2] = r.func;
    exp_rd[3] = {31'd0, r.ctrl};
    @(posedge mclk);
    #2;
    drive_inputs(r);
    write_reg(ADDR_DIR, {8'h00, r.dir});
    write_reg(ADDR_TYPE, {8'h00, r.typ});
    write_reg(ADDR_FUNC, r.func);
    write_reg(ADDR_CTRL, {31'd0, r.ctrl});
    @(posedge mclk);
    @(negedge mclk);
    check_val({tag, " pad_out"}, 32'(pad_out_o), 32'(r.exp_out));
    check_val({tag, " pad_oen"}, 32'(pad_oen_o), 32'(r.exp_oen));
    check_val({tag, " uart_rxd"}, 32'(uart_rxd_o), 32'(r.exp_rxd));
    check_val({tag, " ext_intr"}, 32'(ext_intr_o), 32'(r.exp_int));
    check_val({tag, " spim_mosi"}, 32'(spim_mosi_o), 32'(r.exp_mosi));
    check_val({tag, " i2c_in"}, 32'({i2cm_data_in_o, i2cm_clk_in_o}), 32'(r.exp_i2c));
    check_val({tag, " strap"}, 32'(strap_o), 32'(strap_of(r.pad_in)));
    check_val({tag, " gpio_in"}, 32'(gpio_in_o), 32'(gpio_in_of(r.pad_in)));
    check_val({tag, " pwm_enb"}, 32'(cfg_pwm_enb_o), 32'(r.func[5:0]));
    // Every register read back
    for (int a = 0; a < 4; a++) begin
      @(posedge mclk);
      #2;
      reg_addr_i = reg_addr_t'(a);
      @(negedge mclk);
      check_val($sformatf("%s readback %0d", tag, a), reg_rdata_o, exp_rd[a]);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i       = 1'b1;
    reg_wr_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    pad_in_i    = '0;
    gpio_out_i  = '0;
    pwm_wfm_i   = '0;
    ws_txd_i    = '0;
    uart_txd_i  = '0;
    spim_sck_i  = 1'b0;
    spim_miso_i = 1'b0;
    spim_ssn_i  = '0;
    i2cm_data_i     = 1'b0;
    i2cm_data_oen_i = 1'b1;
    i2cm_clk_i      = 1'b0;
    i2cm_clk_oen_i  = 1'b1;
    load_table();
    repeat (5) @(posedge mclk);
    #2;
    rst_i = 1'b0;
    check_reset();
    foreach (rows[i]) begin
      apply_row(i, rows[i]);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- pinmux_top.f
source/pinmux_pkg.sv
source/pinmux_cfg_regs.sv
source/pinmux_in_route.sv
source/pinmux_out_route.sv
source/pinmux_top.sv
sim/pinmux_top_chk.sv
sim/pinmux_top_tb.sv

//--- Makefile
SRCS := $(shell cat pinmux_top.f)

.PHONY: run clean

run: obj_dir/Vpinmux_top_tb
	./obj_dir/Vpinmux_top_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "NO ERRORS" sim.log

obj_dir/Vpinmux_top_tb: pinmux_top.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module pinmux_top_tb -f pinmux_top.f

clean:
	rm -rf obj_dir sim.log
